//--- hw/riscv_dm_defines.svh
`ifndef RISCV_DM_DEFINES_SVH
`define RISCV_DM_DEFINES_SVH

// data and address width of the core
`define RISCV_XLEN 64

// data memory size in bytes, power of two and at least 8
`define RISCV_DM_DEPTH 32

// byte index width on the memory bus, log2 of the depth
`define RISCV_DM_AW 5

`endif

//--- hw/riscv_isa_pkg.sv
package riscv_isa_pkg;

  // funct3 field of load instructions
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LD  = 3'b011,
    LBU = 3'b100,
    LHU = 3'b101,
    LWU = 3'b110
  } funct3_e;

  // stores reuse the low codes, top bit set is illegal for them
  localparam funct3_e SB = funct3_e'(3'b000);
  localparam funct3_e SH = funct3_e'(3'b001);
  localparam funct3_e SW = funct3_e'(3'b010);
  localparam funct3_e SD = funct3_e'(3'b011);

  // code 111 has no load meaning

endpackage

//--- hw/riscv_mem_pkg.sv
package riscv_mem_pkg;

  // access size on the bus select lines
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HALF  = 2'b01,
    WORD  = 2'b10,
    DWORD = 2'b11
  } dm_size_e;

  // number of bytes touched by one access
  function automatic logic [3:0] size_bytes(dm_size_e sz);
    logic [3:0] n;
    case (sz)
      BYTE:    n = 4'd1;
      HALF:    n = 4'd2;
      WORD:    n = 4'd4;
      default: n = 4'd8;
    endcase
    return n;
  endfunction

endpackage

//--- hw/riscv_dm_if.sv
`timescale 1ns/100ps
`include "riscv_dm_defines.svh"

// memory bus between the load/store control and the data memory
interface riscv_dm_if;

  logic                    wen;    // one cycle per store
  riscv_mem_pkg::dm_size_e sel;    // access size
  logic [`RISCV_DM_AW-1:0] addr;   // byte index
  logic [`RISCV_XLEN-1:0]  wdata;
  logic [`RISCV_XLEN-1:0]  rdata;  // 8 bytes from addr upward

  modport master (
    output wen,
    output sel,
    output addr,
    output wdata,
    input  rdata
  );

  modport slave (
    input  wen,
    input  sel,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

//--- hw/riscv_lsu_ctrl.sv
`timescale 1ns/100ps
`include "riscv_dm_defines.svh"

module riscv_lsu_ctrl (
  input  logic                   i_riscv_dm_rst,    // clock
  input  logic                   i_riscv_dm_clk_n,  // async reset, active low
  input  logic                   i_mem_read,
  input  logic                   i_mem_write,
  input  riscv_isa_pkg::funct3_e i_funct3,
  input  logic [`RISCV_XLEN-1:0] i_addr,
  input  logic [`RISCV_XLEN-1:0] i_store_data,
  output logic                   o_mem_fault,
  riscv_dm_if.master             bus
);

  logic [2:0]              f3_bits;
  riscv_mem_pkg::dm_size_e size;
  logic [2:0]              align_mask;
  logic                    misaligned;
  logic                    ld_legal;
  logic                    st_legal;

  assign f3_bits = i_funct3;

  // low two funct3 bits give the access size for loads and stores alike
  assign size = riscv_mem_pkg::dm_size_e'(f3_bits[1:0]);

  assign align_mask = 3'(riscv_mem_pkg::size_bytes(size) - 4'd1);
  assign misaligned = |(i_addr[2:0] & align_mask);

  always_comb
  begin
    case (i_funct3)
      riscv_isa_pkg::LB,
      riscv_isa_pkg::LH,
      riscv_isa_pkg::LW,
      riscv_isa_pkg::LD,
      riscv_isa_pkg::LBU,
      riscv_isa_pkg::LHU,
      riscv_isa_pkg::LWU: ld_legal = 1'b1;
      default:            ld_legal = 1'b0;  // 111
    endcase
  end

  always_comb
  begin
    case (i_funct3)
      riscv_isa_pkg::SB,
      riscv_isa_pkg::SH,
      riscv_isa_pkg::SW,
      riscv_isa_pkg::SD: st_legal = 1'b1;
      default:           st_legal = 1'b0;   // no unsigned stores
    endcase
  end

  assign o_mem_fault = (i_mem_read  && (misaligned || !ld_legal)) ||
                       (i_mem_write && (misaligned || !st_legal));

  // faulting stores never reach the memory
  assign bus.wen   = i_mem_write && !o_mem_fault;
  assign bus.sel   = size;
  assign bus.addr  = i_addr[`RISCV_DM_AW-1:0];  // upper bits ignored
  assign bus.wdata = i_store_data;

endmodule

//--- hw/riscv_load_ext.sv
`timescale 1ns/100ps
`include "riscv_dm_defines.svh"

module riscv_load_ext (
  input  riscv_isa_pkg::funct3_e i_funct3,
  input  logic [`RISCV_XLEN-1:0] i_rdata,     // lowest byte is at the access address
  output logic [`RISCV_XLEN-1:0] o_load_data
);

  always_comb
  begin
    case (i_funct3)
      riscv_isa_pkg::LB:
        o_load_data = {{(`RISCV_XLEN-8){i_rdata[7]}}, i_rdata[7:0]};
      riscv_isa_pkg::LH:
        o_load_data = {{(`RISCV_XLEN-16){i_rdata[15]}}, i_rdata[15:0]};
      riscv_isa_pkg::LW:
        o_load_data = {{(`RISCV_XLEN-32){i_rdata[31]}}, i_rdata[31:0]};
      riscv_isa_pkg::LBU:
        o_load_data = {{(`RISCV_XLEN-8){1'b0}}, i_rdata[7:0]};
      riscv_isa_pkg::LHU:
        o_load_data = {{(`RISCV_XLEN-16){1'b0}}, i_rdata[15:0]};
      riscv_isa_pkg::LWU:
        o_load_data = {{(`RISCV_XLEN-32){1'b0}}, i_rdata[31:0]};
      default:
        o_load_data = i_rdata;  // LD, and 111 which faults anyway
    endcase
  end

endmodule

//--- hw/riscv_dm.sv
`timescale 1ns/100ps
`include "riscv_dm_defines.svh"

module riscv_dm #(
  parameter int MEM_DEPTH = `RISCV_DM_DEPTH
) (
  input  logic      i_riscv_dm_rst,    // clock
  input  logic      i_riscv_dm_clk_n,  // async reset, active low
  riscv_dm_if.slave bus
);

  localparam int IDX_W = $clog2(MEM_DEPTH);
  localparam int NB    = `RISCV_XLEN / 8;   // bytes per doubleword

  logic [7:0]       mem [MEM_DEPTH];
  logic [IDX_W-1:0] base_idx;
  logic [IDX_W-1:0] byte_idx [NB];
  logic [3:0]       wr_bytes;

  // index taken modulo the depth
  assign base_idx = IDX_W'(bus.addr);

  assign wr_bytes = riscv_mem_pkg::size_bytes(bus.sel);

  // consecutive byte slots, wrapping past the top of the array
  always_comb
  begin
    for (int k = 0; k < NB; k++)
      byte_idx[k] = base_idx + IDX_W'(k);
  end

  // combinational read, lowest byte first
  always_comb
  begin
    for (int k = 0; k < NB; k++)
      bus.rdata[8*k +: 8] = mem[byte_idx[k]];
  end

  always_ff @(posedge i_riscv_dm_rst or negedge i_riscv_dm_clk_n)
  begin
    if (!i_riscv_dm_clk_n)
    begin
      for (int i = 0; i < MEM_DEPTH; i++)
        mem[i] <= 8'h00;
    end
    else if (bus.wen)
    begin
      // only the lowest 1, 2, 4 or 8 bytes of wdata are stored
      for (int k = 0; k < NB; k++)
      begin
        if (k < int'(wr_bytes))
          mem[byte_idx[k]] <= bus.wdata[8*k +: 8];
      end
    end
  end

endmodule

//--- hw/riscv_mem_stage.sv
`timescale 1ns/100ps
`include "riscv_dm_defines.svh"

module riscv_mem_stage (
  input  logic                   i_riscv_dm_rst,    // clock
  input  logic                   i_riscv_dm_clk_n,  // async reset, active low
  input  logic                   i_mem_read,
  input  logic                   i_mem_write,
  input  logic [2:0]             i_funct3,
  input  logic [`RISCV_XLEN-1:0] i_addr,
  input  logic [`RISCV_XLEN-1:0] i_store_data,
  output logic [`RISCV_XLEN-1:0] o_load_data,
  output logic                   o_mem_fault
);

  riscv_isa_pkg::funct3_e funct3;

  riscv_dm_if dm_bus ();

  assign funct3 = riscv_isa_pkg::funct3_e'(i_funct3);

  // decode, alignment check and bus drive
  riscv_lsu_ctrl u_lsu_ctrl (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .i_mem_read       (i_mem_read),
    .i_mem_write      (i_mem_write),
    .i_funct3         (funct3),
    .i_addr           (i_addr),
    .i_store_data     (i_store_data),
    .o_mem_fault      (o_mem_fault),
    .bus              (dm_bus.master)
  );

  riscv_dm #(
    .MEM_DEPTH (`RISCV_DM_DEPTH)
  ) u_dm (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .bus              (dm_bus.slave)
  );

  // read data goes straight to the extender
  riscv_load_ext u_load_ext (
    .i_funct3    (funct3),
    .i_rdata     (dm_bus.rdata),
    .o_load_data (o_load_data)
  );

endmodule

//--- verification/riscv_mem_stage_chk.sv
`timescale 1ns/100ps
`include "riscv_dm_defines.svh"

module riscv_mem_stage_chk (
  input logic                   i_riscv_dm_rst,    // clock
  input logic                   i_riscv_dm_clk_n,  // async reset, active low
  input logic                   i_mem_read,
  input logic                   i_mem_write,
  input logic [2:0]             i_funct3,
  input logic [`RISCV_XLEN-1:0] i_addr,
  input logic                   i_wen,             // write strobe on the memory bus
  input logic                   i_mem_fault
);

  logic [2:0] dword_mask;
  logic       dword_store_mis;

  assign dword_mask = 3'(riscv_mem_pkg::size_bytes(riscv_mem_pkg::DWORD) - 4'd1);

  // store of eight bytes off an 8-byte boundary
  assign dword_store_mis = i_mem_write &&
                           (i_funct3[1:0] == 2'(riscv_mem_pkg::DWORD)) &&
                           ((i_addr[2:0] & dword_mask) != 3'd0);

  a_no_wen_on_fault: assert property (
    @(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    i_mem_fault |-> !i_wen)
    else $error("write strobe raised while the access faults");

  a_fault_needs_access: assert property (
    @(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    !(i_mem_read || i_mem_write) |-> !i_mem_fault)
    else $error("fault flag raised with no access presented");

  a_dword_misaligned: assert property (
    @(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    dword_store_mis |-> i_mem_fault)
    else $error("misaligned doubleword store did not fault");

endmodule

bind riscv_mem_stage riscv_mem_stage_chk u_chk (
  .i_riscv_dm_rst   (i_riscv_dm_rst),
  .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
  .i_mem_read       (i_mem_read),
  .i_mem_write      (i_mem_write),
  .i_funct3         (i_funct3),
  .i_addr           (i_addr),
  .i_wen            (dm_bus.wen),
  .i_mem_fault      (o_mem_fault)
);

//--- verification/riscv_mem_stage_tb.sv
`timescale 1ns/100ps
`include "riscv_dm_defines.svh"

module riscv_mem_stage_tb;

  localparam int DEPTH       = `RISCV_DM_DEPTH;
  localparam int CLK_HALF_NS = 50;
  localparam int WATCHDOG_NS = 40000;   // well past the full test run

  logic                   clk;
  logic                   rst_n;
  logic                   mem_read;
  logic                   mem_write;
  logic [2:0]             funct3;
  logic [`RISCV_XLEN-1:0] addr;
  logic [`RISCV_XLEN-1:0] store_data;
  logic [`RISCV_XLEN-1:0] load_data;
  logic                   mem_fault;

  logic [7:0] ref_mem [DEPTH];   // reference copy of the data memory
  int         n_checks;
  int         n_errors;
  int         seed;

  riscv_mem_stage i_riscv_mem_stage (
    .i_riscv_dm_rst   (clk),
    .i_riscv_dm_clk_n (rst_n),
    .i_mem_read       (mem_read),
    .i_mem_write      (mem_write),
    .i_funct3         (funct3),
    .i_addr           (addr),
    .i_store_data     (store_data),
    .o_load_data      (load_data),
    .o_mem_fault      (mem_fault)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_HALF_NS) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  // 1, 2, 4 or 8 from the low funct3 bits
  function automatic int access_bytes(input logic [2:0] f3);
    return 1 << f3[1:0];
  endfunction

  function automatic logic expect_fault(input logic rd, input logic wr,
                                        input logic [2:0] f3, input logic [63:0] a);
    logic mis;
    mis = (int'(a[2:0]) % access_bytes(f3)) != 0;
    return (rd && (mis || f3 == 3'b111)) || (wr && (mis || f3[2]));
  endfunction

  function automatic logic [63:0] model_load(input logic [63:0] a, input logic [2:0] f3);
    int          n;
    int          base;
    logic [63:0] val;
    n    = access_bytes(f3);
    base = int'(a % 64'(DEPTH));
    val  = '0;
    for (int k = 0; k < n; k++)
      val[8*k +: 8] = ref_mem[(base + k) % DEPTH];
    // signed loads copy the top loaded bit upward
    if (!f3[2] && n < 8 && val[8*n-1])
    begin
      for (int k = n; k < 8; k++)
        val[8*k +: 8] = 8'hff;
    end
    return val;
  endfunction

  task automatic store_access(input string name, input logic [63:0] a,
                              input logic [2:0] f3, input logic [63:0] d);
    logic exp_fault;
    int   base;
    exp_fault = expect_fault(1'b0, 1'b1, f3, a);
    base      = int'(a % 64'(DEPTH));
    @(posedge clk);
    mem_read   <= 1'b0;
    mem_write  <= 1'b1;
    funct3     <= f3;
    addr       <= a;
    store_data <= d;
    if (!exp_fault)
    begin
      for (int k = 0; k < access_bytes(f3); k++)
        ref_mem[(base + k) % DEPTH] = d[8*k +: 8];
    end
    @(negedge clk);
    n_checks++;
    if (mem_fault !== exp_fault)
    begin
      n_errors++;
      $display("[FAIL] %s store fault: expected %b, actual %b", name, exp_fault, mem_fault);
    end
  endtask

  task automatic load_access(input string name, input logic [63:0] a,
                             input logic [2:0] f3);
    logic        exp_fault;
    logic [63:0] exp_data;
    exp_fault = expect_fault(1'b1, 1'b0, f3, a);
    exp_data  = model_load(a, f3);
    @(posedge clk);
    mem_read  <= 1'b1;
    mem_write <= 1'b0;
    funct3    <= f3;
    addr      <= a;
    @(negedge clk);
    n_checks++;
    if (mem_fault !== exp_fault)
    begin
      n_errors++;
      $display("[FAIL] %s load fault: expected %b, actual %b", name, exp_fault, mem_fault);
    end
    if (!exp_fault)
    begin
      n_checks++;
      if (load_data !== exp_data)
      begin
        n_errors++;
        $display("[FAIL] %s load data at %h: expected %h, actual %h",
                 name, a, exp_data, load_data);
      end
    end
  endtask

  task automatic bus_idle(input string name);
    @(posedge clk);
    mem_read  <= 1'b0;
    mem_write <= 1'b0;
    @(negedge clk);
    n_checks++;
    if (mem_fault !== 1'b0)
    begin
      n_errors++;
      $display("[FAIL] %s idle fault: expected 0, actual %b", name, mem_fault);
    end
  endtask

  task automatic test_reset();
    for (int i = 0; i < DEPTH; i += 8)
      load_access("test_reset", 64'(i), riscv_isa_pkg::LD);
  endtask

  task automatic test_roundtrip();
    int          n;
    int          idx;
    logic [63:0] data;
    logic [2:0]  ld_f3;
    for (int sz = 0; sz < 4; sz++)
    begin
      n     = 1 << sz;
      ld_f3 = (sz == 3) ? 3'b011 : 3'(sz + 4);   // LD, else the unsigned load of that size
      for (int i = 0; i < 10; i++)
      begin
        idx  = int'($unsigned($random(seed)) % DEPTH);
        idx  = idx - (idx % n);                  // align to the access size
        data = {$random(seed), $random(seed)};
        store_access("test_roundtrip", 64'(idx), 3'(sz), data);
        load_access("test_roundtrip", 64'(idx), ld_f3);
      end
    end
  endtask

  task automatic test_extend();
    int         offs  [6];
    logic [1:0] sizes [6];
    offs  = '{0, 1, 0, 2, 0, 4};
    sizes = '{2'd0, 2'd0, 2'd1, 2'd1, 2'd2, 2'd2};
    // neighbouring bytes, halves and words alternate the top bit
    store_access("test_extend", 64'd8, riscv_isa_pkg::SD, 64'h7fff_ffff_8000_7f80);
    for (int i = 0; i < 6; i++)
    begin
      load_access("test_extend", 64'(8 + offs[i]), {1'b0, sizes[i]});  // signed
      load_access("test_extend", 64'(8 + offs[i]), {1'b1, sizes[i]});  // unsigned
    end
  endtask

  task automatic test_partial();
    store_access("test_partial", 64'd16, riscv_isa_pkg::SD, 64'h0123_4567_89ab_cdef);
    store_access("test_partial", 64'd19, riscv_isa_pkg::SB, 64'hffff_ffff_ffff_ff5a);
    load_access("test_partial", 64'd16, riscv_isa_pkg::LD);
    store_access("test_partial", 64'd22, riscv_isa_pkg::SH, 64'hffff_ffff_ffff_a5c3);
    load_access("test_partial", 64'd16, riscv_isa_pkg::LD);
    load_access("test_partial", 64'd24, riscv_isa_pkg::LD);   // next doubleword too
  endtask

  task automatic test_fault();
    store_access("test_fault", 64'd0, riscv_isa_pkg::SD, 64'h1111_2222_3333_4444);
    store_access("test_fault", 64'd8, riscv_isa_pkg::SD, 64'h5555_6666_7777_8888);
    store_access("test_fault", 64'd1, riscv_isa_pkg::SH, 64'hffff_ffff_ffff_ffff);
    store_access("test_fault", 64'd2, riscv_isa_pkg::SW, 64'hffff_ffff_ffff_ffff);
    store_access("test_fault", 64'd4, riscv_isa_pkg::SD, 64'hffff_ffff_ffff_ffff);
    store_access("test_fault", 64'd0, 3'b100, 64'hffff_ffff_ffff_ffff);   // no unsigned stores
    store_access("test_fault", 64'd8, 3'b111, 64'hffff_ffff_ffff_ffff);
    load_access("test_fault", 64'd3, riscv_isa_pkg::LH);
    load_access("test_fault", 64'd6, riscv_isa_pkg::LW);
    load_access("test_fault", 64'd5, riscv_isa_pkg::LD);
    load_access("test_fault", 64'd0, 3'b111);
    load_access("test_fault", 64'd0, riscv_isa_pkg::LD);
    load_access("test_fault", 64'd8, riscv_isa_pkg::LD);
  endtask

  task automatic test_wrap();
    // upper address bits must not matter
    store_access("test_wrap", 64'hdead_beef_0000_0028, riscv_isa_pkg::SD,
                 64'h0f1e_2d3c_4b5a_6978);
    load_access("test_wrap", 64'd8, riscv_isa_pkg::LD);
    store_access("test_wrap", 64'h0000_0001_0000_0014, riscv_isa_pkg::SW,
                 64'h0000_0000_cafe_f00d);
    load_access("test_wrap", 64'h8000_0000_0000_0010, riscv_isa_pkg::LD);
    load_access("test_wrap", 64'hffff_ffff_ffff_ffe0, riscv_isa_pkg::LD);
  endtask

  initial
  begin
    seed       = 52;
    n_checks   = 0;
    n_errors   = 0;
    rst_n      = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    funct3     = 3'b000;
    addr       = '0;
    store_data = '0;
    for (int i = 0; i < DEPTH; i++)
      ref_mem[i] = 8'h00;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    test_reset();
    test_roundtrip();
    test_extend();
    test_partial();
    test_fault();
    test_wrap();
    bus_idle("end of run");

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- sim.f
+incdir+hw
hw/riscv_isa_pkg.sv
hw/riscv_mem_pkg.sv
hw/riscv_dm_if.sv
hw/riscv_lsu_ctrl.sv
hw/riscv_load_ext.sv
hw/riscv_dm.sv
hw/riscv_mem_stage.sv
verification/riscv_mem_stage_chk.sv
verification/riscv_mem_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module riscv_mem_stage_tb -o riscv_mem_stage_sim; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/riscv_mem_stage_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "NO ERRORS" <<< "$sim_out"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1
